//--- common/routerPkg.sv
package routerPkg;

  localparam int NumPorts = 5;
  localparam int LengthW = 12;
  localparam int PayloadW = 16;

  typedef enum logic [2:0] {
    PortLocal = 3'd0,
    PortNorth = 3'd1,
    PortEast  = 3'd2,
    PortWest  = 3'd3,
    PortSouth = 3'd4
  } portIdT;

  typedef enum logic [2:0] {
    FlitHeader = 3'd1,
    FlitBody   = 3'd2,
    FlitTail   = 3'd3
  } flitKindT;

  typedef struct packed {
    flitKindT            kind;
    logic [LengthW-1:0]  length;   // Flits per grant, header only
    logic [PayloadW-1:0] payload;
  } flitT;

  // One-hot, bit 0 is idle and bit n+1 grants port n
  typedef enum logic [5:0] {
    Idle   = 6'b000001,
    GrantL = 6'b000010,
    GrantN = 6'b000100,
    GrantE = 6'b001000,
    GrantW = 6'b010000,
    GrantS = 6'b100000
  } arbStateT;

  function automatic arbStateT grantState(input int unsigned port);
    return arbStateT'(6'b000010 << port);
  endfunction

  function automatic int unsigned statePort(input arbStateT s);
    int unsigned port;
    port = 0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (s[i + 1])
        port = i;
    end
    return port;
  endfunction

  function automatic portIdT onehotToPort(input logic [NumPorts-1:0] vec);
    portIdT port;
    port = PortLocal;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (vec[i])
        port = portIdT'(i);
    end
    return port;
  endfunction

endpackage

//--- verilog/inputBuffer.sv
`timescale 1ns/100ps

module inputBuffer #(
  parameter int BufferDepth = 8
) (
  input  logic            clk,
  input  logic            rst,
  input  routerPkg::flitT wrFlit,
  input  logic            wrValid,
  input  logic            pop,
  output routerPkg::flitT headFlit,
  output logic            req,
  output logic            full
);
  import routerPkg::*;

  localparam int PtrW = $clog2(BufferDepth);

  flitT mem [BufferDepth];

  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic [PtrW:0]   count;   // Occupancy
  logic            doWrite;
  logic            doRead;

  assign full    = (count == (PtrW+1)'(BufferDepth));
  assign req     = (count != '0);
  assign doWrite = wrValid && !full;   // Dropped when full
  assign doRead  = pop && req;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= wrFlit;
  end

  assign headFlit = mem[rdPtr];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pointers and count

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= wrPtr + 1'b1;   // Wraps at depth
      if (doRead)
        rdPtr <= rdPtr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else
    begin
      case ({doWrite, doRead})
        2'b10:
          count <= count + 1'b1;
        2'b01:
          count <= count - 1'b1;
        default:
          count <= count;
      endcase
    end
  end

endmodule

//--- arbiter/grantTimer.sv
`timescale 1ns/100ps

module grantTimer (
  input  logic            clk,
  input  logic            rst,
  input  routerPkg::flitT headFlit,
  input  logic            run,
  output logic            timesUp
);
  import routerPkg::*;

  logic [LengthW-1:0] limit;   // Length from last header seen
  logic [LengthW-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
      limit <= '0;
    else if (headFlit.kind == FlitHeader)
      limit <= headFlit.length;
  end

  // Counts transfers of the current grant
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else
    begin
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == limit);

endmodule

//--- arbiter/arbiter.sv
`timescale 1ns/100ps

module arbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  routerPkg::flitT                headFlit [routerPkg::NumPorts],
  input  logic [routerPkg::NumPorts-1:0] req,
  output logic [routerPkg::NumPorts-1:0] xferPort
);
  import routerPkg::*;

  arbStateT            state;
  arbStateT            nextState;
  logic [NumPorts-1:0] timesUp;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Grant timers

  for (genvar i = 0; i < NumPorts; i++)
  begin : gTimer
    grantTimer i_timer (
      .clk     (clk),
      .rst     (rst),
      .headFlit(headFlit[i]),
      .run     (xferPort[i]),   // Counts only while moving flits
      .timesUp (timesUp[i])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State register

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= Idle;
    else
      state <= nextState;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state and transfer enables

  always_comb
  begin
    int unsigned cur;
    int unsigned idx;
    logic        found;

    cur       = statePort(state);
    idx       = 0;
    found     = 1'b0;
    nextState = Idle;
    xferPort  = '0;

    case (state)
      Idle:
      begin
        // Fixed priority L N E W S
        for (int i = 0; i < NumPorts; i++)
        begin
          if (req[i] && !found)
          begin
            nextState = grantState(i);
            found     = 1'b1;
          end
        end
      end

      GrantL, GrantN, GrantE, GrantW, GrantS:
      begin
        if (req[cur] && !timesUp[cur])
        begin
          xferPort[cur] = 1'b1;   // Hold the link
          nextState     = state;
        end
        else
        begin
          // Rotate starting after the current port
          for (int k = 1; k < NumPorts; k++)
          begin
            idx = (cur + k) % NumPorts;
            if (req[idx] && !found)
            begin
              nextState = grantState(idx);
              found     = 1'b1;
            end
          end
        end
      end

      default:
        nextState = Idle;
    endcase
  end

endmodule

//--- verilog/switchTraversal.sv
`timescale 1ns/100ps

module switchTraversal (
  input  logic                           clk,
  input  logic                           rst,
  input  routerPkg::flitT                headFlit [routerPkg::NumPorts],
  input  logic [routerPkg::NumPorts-1:0] xferPort,
  output logic [routerPkg::NumPorts-1:0] pop,
  output routerPkg::flitT                outFlit,
  output logic                           outValid,
  output routerPkg::portIdT              outPort
);
  import routerPkg::*;

  portIdT selPort;
  logic   anyXfer;

  assign pop     = xferPort;   // Transfer drains the head
  assign anyXfer = |xferPort;
  assign selPort = onehotToPort(xferPort);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output link register

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= anyXfer;
  end

  // Flit and source port only load on a transfer
  always_ff @(posedge clk)
  begin
    if (anyXfer)
    begin
      outFlit <= headFlit[selPort];
      outPort <= selPort;
    end
  end

endmodule

//--- verilog/routerOutputChannel.sv
`timescale 1ns/100ps

module routerOutputChannel #(
  parameter int BufferDepth = 8
) (
  input  logic                           clk,
  input  logic                           rst,
  input  routerPkg::flitT                inFlit [routerPkg::NumPorts],
  input  logic [routerPkg::NumPorts-1:0] inValid,
  output logic [routerPkg::NumPorts-1:0] bufferFull,
  output routerPkg::flitT                outFlit,
  output logic                           outValid,
  output routerPkg::portIdT              outPort
);
  import routerPkg::*;

  flitT                headFlit [NumPorts];
  logic [NumPorts-1:0] req;
  logic [NumPorts-1:0] pop;
  logic [NumPorts-1:0] xferPort;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input buffers, one per port

  for (genvar i = 0; i < NumPorts; i++)
  begin : gPort
    inputBuffer #(
      .BufferDepth(BufferDepth)
    ) i_buffer (
      .clk     (clk),
      .rst     (rst),
      .wrFlit  (inFlit[i]),
      .wrValid (inValid[i]),
      .pop     (pop[i]),
      .headFlit(headFlit[i]),
      .req     (req[i]),
      .full    (bufferFull[i])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arbitration and switch

  arbiter i_arbiter (
    .clk     (clk),
    .rst     (rst),
    .headFlit(headFlit),
    .req     (req),
    .xferPort(xferPort)
  );

  switchTraversal i_switch (
    .clk     (clk),
    .rst     (rst),
    .headFlit(headFlit),
    .xferPort(xferPort),
    .pop     (pop),
    .outFlit (outFlit),
    .outValid(outValid),
    .outPort (outPort)   // Registered with the flit
  );

endmodule

//--- test/routerChannel_assert.sv
`timescale 1ns/100ps

module routerChannelAssert (
  input logic                           clk,
  input logic                           rst,
  input logic [routerPkg::NumPorts-1:0] xferPort,
  input logic [routerPkg::NumPorts-1:0] req,
  input logic [routerPkg::NumPorts-1:0] pop,
  input logic                           outValid
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Grant and pop rules

  aXferOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(xferPort))
  else $error("more than one port transfers in the same cycle");

  aPopNeedsReq: assert property (@(posedge clk) disable iff (rst) (pop & ~req) == '0)
  else $error("pop issued to an empty input buffer");

  // Link register is one cycle behind the transfer
  aValidAfterXfer: assert property (@(posedge clk) disable iff (rst) (|xferPort) |=> outValid)
  else $error("outValid missing one cycle after a transfer");

  aQuietAfterIdle: assert property (@(posedge clk) disable iff (rst) !(|xferPort) |=> !outValid)
  else $error("outValid raised without a transfer");

endmodule

bind routerOutputChannel routerChannelAssert i_assert (
  .clk     (clk),
  .rst     (rst),
  .xferPort(xferPort),
  .req     (req),
  .pop     (pop),
  .outValid(outValid)
);

//--- test/tbRouterOutputChannel.sv
`timescale 1ns/100ps

module tbRouterOutputChannel;
  import routerPkg::*;

  localparam int BufferDepth = 8;
  localparam int NumTests    = 5;
  localparam int RowTimeout  = 400;

  typedef struct packed {
    logic [2:0]  port;
    logic [11:0] length;   // Header length field
    logic [7:0]  count;    // Flits in the packet
    logic [7:0]  start;    // Write offset, staggered rows only
  } pktSpecT;

  logic                clk;
  logic                rst;
  flitT                inFlit [NumPorts];
  logic [NumPorts-1:0] inValid;
  logic [NumPorts-1:0] bufferFull;
  flitT                outFlit;
  logic                outValid;
  portIdT              outPort;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus table

  string   testName   [NumTests];
  logic    staggered  [NumTests];
  int      numPkts    [NumTests];
  portIdT  firstPort  [NumTests];
  logic    expectDrop [NumTests];
  pktSpecT pktTable   [NumTests][NumPorts];

  // Reference model state
  flitT        mQueue [NumPorts][$];
  int          mState;   // -1 is idle
  int          mCount [NumPorts];
  logic [11:0] mLimit [NumPorts];
  logic        expValid;
  flitT        expFlit;
  int          expPort;

  flitT   pktFlits [NumPorts][$];
  int     pktStart [NumPorts];
  int     burstLimit [NumPorts];
  string  curTest;
  int     curRow;
  int     beats;
  int     runLen;
  logic   prevValid;
  portIdT prevPort;
  logic   sawFull;
  int     dropped;
  integer seed;

  routerOutputChannel #(
    .BufferDepth(BufferDepth)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .inFlit    (inFlit),
    .inValid   (inValid),
    .bufferFull(bufferFull),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .outPort   (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #4 clk = ~clk;
  end

  function automatic pktSpecT makePacket(input int port, input int len, input int cnt,
                                         input int start);
    pktSpecT spec;
    spec.port   = port[2:0];
    spec.length = len[11:0];
    spec.count  = cnt[7:0];
    spec.start  = start[7:0];
    return spec;
  endfunction

  task automatic setRow(input int row, input string name, input logic stag, input int n,
                        input portIdT first, input logic drop);
    testName[row]   = name;
    staggered[row]  = stag;
    numPkts[row]    = n;
    firstPort[row]  = first;
    expectDrop[row] = drop;
  endtask

  task automatic loadTable;
    setRow(0, "singleLocal", 1'b0, 1, PortLocal, 1'b0);
    pktTable[0][0] = makePacket(PortLocal, 4, 4, 0);
    setRow(1, "priorityIdle", 1'b0, 5, PortLocal, 1'b0);
    for (int p = 0; p < NumPorts; p++)
      pktTable[1][p] = makePacket(p, 3, 3, 0);
    setRow(2, "grantLimit", 1'b0, 3, PortLocal, 1'b0);
    pktTable[2][0] = makePacket(PortLocal, 2, 5, 0);   // Split over three grants
    pktTable[2][1] = makePacket(PortNorth, 2, 2, 0);
    pktTable[2][2] = makePacket(PortEast, 3, 3, 0);
    setRow(3, "rotationWrap", 1'b1, 3, PortSouth, 1'b0);
    pktTable[3][0] = makePacket(PortSouth, 4, 4, 0);
    pktTable[3][1] = makePacket(PortWest, 2, 2, 2);
    pktTable[3][2] = makePacket(PortNorth, 2, 2, 2);
    setRow(4, "overflow", 1'b0, 1, PortLocal, 1'b1);
    pktTable[4][0] = makePacket(PortLocal, 1, 16, 0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Failure reporting

  task automatic stopOnFailure;
    $display("Verification failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic reportValue(input string what, input logic [63:0] expVal,
                             input logic [63:0] actVal);
    $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h", curTest, what, expVal, actVal);
    stopOnFailure();
  endtask

  task automatic reportProblem(input string msg);
    $display("[%s] %s", curTest, msg);
    stopOnFailure();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model of the arbitration rule

  task automatic resetModel;
    for (int p = 0; p < NumPorts; p++)
    begin
      mQueue[p].delete();
      mCount[p] = 0;
      mLimit[p] = '0;
    end
    mState    = -1;
    expValid  = 1'b0;
    prevValid = 1'b0;
    runLen    = 0;
  endtask

  task automatic modelStep;
    int                  xfer;
    int                  nextState;
    int                  cand;
    logic [NumPorts-1:0] full;

    xfer = -1;
    nextState = -1;
    for (int p = 0; p < NumPorts; p++)
      full[p] = (mQueue[p].size() == BufferDepth);
    if (mState < 0)
    begin
      for (int p = NumPorts - 1; p >= 0; p--)   // Lowest port wins
      begin
        if (mQueue[p].size() != 0)
          nextState = p;
      end
    end
    else if (mQueue[mState].size() != 0 && mCount[mState] != int'(mLimit[mState]))
    begin
      xfer      = mState;
      nextState = mState;
    end
    else
    begin
      for (int k = NumPorts - 1; k >= 1; k--)
      begin
        cand = (mState + k) % NumPorts;
        if (mQueue[cand].size() != 0)
          nextState = cand;
      end
    end
    for (int p = 0; p < NumPorts; p++)
    begin
      if (mQueue[p].size() != 0 && mQueue[p][0].kind == FlitHeader)
        mLimit[p] = mQueue[p][0].length;
      mCount[p] = (p == xfer) ? mCount[p] + 1 : 0;
    end
    expValid = (xfer >= 0);
    if (xfer >= 0)
    begin
      expFlit = mQueue[xfer].pop_front();
      expPort = xfer;
    end
    for (int p = 0; p < NumPorts; p++)
    begin
      if (inValid[p] && !full[p])
        mQueue[p].push_back(inFlit[p]);
    end
    mState = nextState;
  endtask

  task automatic checkOutputs;
    logic [NumPorts-1:0] expFull;

    for (int p = 0; p < NumPorts; p++)
    begin
      expFull[p] = (mQueue[p].size() == BufferDepth);
      if (inValid[p] && bufferFull[p])
        dropped++;   // Write refused by the DUT
    end
    assert (bufferFull === expFull)
    else reportValue("bufferFull", expFull, bufferFull);
    if (|bufferFull)
      sawFull = 1'b1;
    assert (outValid === expValid)
    else reportValue("outValid", expValid, outValid);
    if (expValid)
    begin
      assert (outPort === portIdT'(expPort))
      else reportValue("outPort", expPort, outPort);
      assert (outFlit === expFlit)
      else reportValue("outFlit", expFlit, outFlit);
      if (beats == 0)
      begin
        assert (outPort === firstPort[curRow])
        else reportValue("first granted port", firstPort[curRow], outPort);
      end
      assert (!prevValid || outPort == prevPort)
      else reportProblem("two ports were sent without an idle cycle between grants");
      runLen = prevValid ? runLen + 1 : 1;
      assert (runLen <= burstLimit[expPort])
      else reportProblem("a burst ran past the header length");
      beats++;
    end
    prevValid = outValid;
    prevPort  = outPort;
  endtask

  task automatic clockCycle;
    @(negedge clk);   // Outputs are settled here
    checkOutputs();
    modelStep();
    @(posedge clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Row application

  task automatic applyRow(input int row);
    pktSpecT    spec;
    flitT       f;
    logic [31:0] rnd;
    int         lastWrite;
    int         stored;
    int         cyc;
    int         idx;
    logic       done;

    curTest   = testName[row];
    curRow    = row;
    beats     = 0;
    dropped   = 0;
    sawFull   = 1'b0;
    lastWrite = 0;
    stored    = 0;
    for (int p = 0; p < NumPorts; p++)
    begin
      pktFlits[p].delete();
      pktStart[p]   = 0;
      burstLimit[p] = 0;
    end
    for (int i = 0; i < numPkts[row]; i++)
    begin
      spec = pktTable[row][i];
      pktStart[spec.port]   = staggered[row] ? int'(spec.start) : 0;
      burstLimit[spec.port] = spec.length;
      for (int j = 0; j < int'(spec.count); j++)
      begin
        rnd       = $random(seed);
        f.payload = rnd[15:0];
        f.length  = (j == 0) ? spec.length : '0;
        if (j == 0)
          f.kind = FlitHeader;
        else if (j == int'(spec.count) - 1)
          f.kind = FlitTail;
        else
          f.kind = FlitBody;
        pktFlits[spec.port].push_back(f);
      end
      if (pktStart[spec.port] + int'(spec.count) > lastWrite)
        lastWrite = pktStart[spec.port] + int'(spec.count);
      stored += spec.count;
    end

    cyc  = 0;
    done = 1'b0;
    while (!done)
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        idx = cyc - pktStart[p];
        if (idx >= 0 && idx < pktFlits[p].size())
        begin
          inValid[p] <= 1'b1;
          inFlit[p]  <= pktFlits[p][idx];
        end
        else
          inValid[p] <= 1'b0;
      end
      clockCycle();
      cyc++;
      done = (cyc > lastWrite) && !expValid && (mState < 0);
      for (int p = 0; p < NumPorts; p++)
        done = done && (mQueue[p].size() == 0);
      assert (cyc <= RowTimeout)
      else reportProblem("timed out waiting for the output link to drain");
    end

    assert (sawFull == expectDrop[row])
    else reportValue("bufferFull seen", expectDrop[row], sawFull);
    assert ((dropped > 0) == expectDrop[row])
    else reportValue("dropped flits", expectDrop[row], dropped);
    assert (beats == stored - dropped)
    else reportValue("beat count", stored - dropped, beats);
  endtask

  initial
  begin
    seed       = 32'h3c4ee97e;
    rst        = 1'b1;
    inValid    = '0;
    curTest    = "reset";
    curRow     = 0;
    beats      = 0;
    for (int p = 0; p < NumPorts; p++)
      inFlit[p] = '0;
    loadTable();
    resetModel();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // Link must stay quiet after reset
    for (int i = 0; i < 4; i++)
    begin
      inValid <= '0;
      clockCycle();
    end
    for (int r = 0; r < NumTests; r++)
      applyRow(r);
    // Nothing more leaves once all queues drained
    for (int i = 0; i < 4; i++)
    begin
      inValid <= '0;
      clockCycle();
    end
    $display("Verification passed");
    $finish;
  end

endmodule

//--- filelist.f
common/routerPkg.sv
verilog/inputBuffer.sv
arbiter/grantTimer.sv
arbiter/arbiter.sv
verilog/switchTraversal.sv
verilog/routerOutputChannel.sv
test/routerChannel_assert.sv
test/tbRouterOutputChannel.sv
